// ==== async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                      arst_n,
    input  logic                      flush,

    input  logic                      w_clk,
    output logic                      w_ready,
    input  logic                      w_trigger,
    input  logic [img_pkg::WORD_W-1:0] w_data,

    input  logic                      r_clk,
    output logic                      r_ready,
    input  logic                      r_trigger,
    output logic [img_pkg::WORD_W-1:0] r_data
);

    localparam int AW = DEPTH_LOG2;

    logic                      rst_n;
    logic [img_pkg::WORD_W-1:0] mem [2**AW];

    logic [AW:0] wbin;
    logic [AW:0] wbin_next;
    logic [AW:0] wgray;
    logic [AW:0] rgray_w1;
    logic [AW:0] rgray_w2;

    logic [AW:0] rbin;
    logic [AW:0] rbin_next;
    logic [AW:0] rgray;
    logic [AW:0] wgray_r1;
    logic [AW:0] wgray_r2;

    // Flush clears both sides at once
    assign rst_n = arst_n & ~flush;

    // ============================================================
    // Write side
    // ============================================================
    assign wbin_next = wbin + {{AW{1'b0}}, w_trigger & w_ready};

    // Full when the pointers differ only in the two top Gray bits
    assign w_ready = wgray != {~rgray_w2[AW:AW-1], rgray_w2[AW-2:0]};

    always_ff @(posedge w_clk or negedge rst_n) begin
        if (!rst_n) begin
            wbin <= '0;
            wgray <= '0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            wbin <= wbin_next;
            wgray <= wbin_next ^ (wbin_next >> 1);
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_trigger && w_ready) begin
            mem[wbin[AW-1:0]] <= w_data;
        end
    end

    // ============================================================
    // Read side
    // ============================================================
    assign rbin_next = rbin + {{AW{1'b0}}, r_trigger & r_ready};
    assign r_ready = rgray != wgray_r2;
    // Head word is visible while r_ready is high
    assign r_data = mem[rbin[AW-1:0]];

    always_ff @(posedge r_clk or negedge rst_n) begin
        if (!rst_n) begin
            rbin <= '0;
            rgray <= '0;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            rbin <= rbin_next;
            rgray <= rbin_next ^ (rbin_next >> 1);
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
img_pkg.sv
toggle_sync.sv
async_fifo.sv
pixel_capture.sv
frame_store.sv
img_controller.sv
img_controller_chk.sv
tb_img_controller.sv

// ==== frame_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_store #(
    parameter int IMAGE_WORDS_MAX = 256
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  img_pkg::ram_cmd_e          cmd,
    input  logic                       block,
    output logic                       write_ready,
    input  logic                       write_trigger,
    input  logic [img_pkg::WORD_W-1:0]  write_data,
    output logic                       read_ready,
    input  logic                       read_trigger,
    output logic [img_pkg::WORD_W-1:0]  read_data
);

    localparam int ADDR_W = $clog2(IMAGE_WORDS_MAX);
    localparam logic [ADDR_W:0] END_ADDR = (ADDR_W + 1)'(IMAGE_WORDS_MAX);

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_WRITE,
        MODE_READ
    } mode_e;

    logic [img_pkg::WORD_W-1:0] mem [2*IMAGE_WORDS_MAX];
    mode_e                     mode;
    logic                      blk;
    logic [ADDR_W:0]           addr;
    logic [ADDR_W:0]           mem_addr;
    logic                      rd_valid;
    logic                      at_end;
    logic                      do_write;
    logic                      do_fetch;

    assign at_end = addr == END_ADDR;
    assign mem_addr = {blk, addr[ADDR_W-1:0]};
    assign write_ready = mode == MODE_WRITE && !at_end;
    assign do_write = write_ready && write_trigger;
    // Refill the output register when it is empty or being taken
    assign do_fetch = mode == MODE_READ && !at_end && (!rd_valid || read_trigger);
    assign read_ready = rd_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode <= MODE_IDLE;
            blk <= 1'b0;
            addr <= '0;
            rd_valid <= 1'b0;
        end else if (cmd != img_pkg::CMD_NONE) begin
            addr <= '0;
            rd_valid <= 1'b0;
            blk <= block;
            case (cmd)
                img_pkg::CMD_WRITE: mode <= MODE_WRITE;
                img_pkg::CMD_READ:  mode <= MODE_READ;
                default:            mode <= MODE_IDLE;
            endcase
        end else begin
            if (do_write || do_fetch) begin
                addr <= addr + 1'b1;
            end
            if (do_fetch) begin
                rd_valid <= 1'b1;
            end else if (read_trigger) begin
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[mem_addr] <= write_data;
        end
        if (do_fetch) begin
            read_data <= mem[mem_addr];
        end
    end

endmodule

`default_nettype wire

// ==== img_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module img_controller #(
    parameter int IMAGE_WORDS_MAX = 256,
    parameter int HEADER_WORDS = 4,
    parameter int FIFO_DEPTH_LOG2 = 4,
    localparam int CNT_W = $clog2(IMAGE_WORDS_MAX + 1)
) (
    input  logic                                  clk,
    input  logic                                  readout_clk,
    input  logic                                  img_dclk,
    input  logic                                  arst_n,
    input  logic                                  cmd_capture,
    input  logic                                  cmd_readout,
    input  logic                                  cmd_block,
    input  logic [HEADER_WORDS*img_pkg::WORD_W-1:0] cmd_header,
    output logic                                  readout_ready,
    input  logic                                  readout_trigger,
    output logic [img_pkg::WORD_W-1:0]             readout_data,
    output logic                                  capture_done,
    output logic [CNT_W-1:0]                      capture_word_count,
    output logic [img_pkg::STAT_W-1:0]             highlight_count,
    output logic [img_pkg::STAT_W-1:0]             shadow_count,
    input  logic [img_pkg::PIXEL_W-1:0]            img_d,
    input  logic                                  img_fv,
    input  logic                                  img_lv
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAP_ISSUE,
        ST_CAP_WAIT_READY,
        ST_CAP_WAIT_STARTED,
        ST_CAP_COPY,
        ST_RD_ISSUE,
        ST_RD_WAIT,
        ST_RD_DRAIN
    } state_e;

    state_e                    state;
    img_pkg::ram_cmd_e         fs_cmd;
    logic                      fs_block;
    logic                      fs_write_ready;
    logic                      wr_valid;
    logic [img_pkg::WORD_W-1:0] wr_data;
    logic                      fs_read_ready;
    logic                      fs_read_trigger;
    logic [img_pkg::WORD_W-1:0] fs_read_data;

    logic                      fi_flush;
    logic                      fi_write;
    logic [img_pkg::WORD_W-1:0] fi_data;
    logic                      fi_w_ready;
    logic                      fi_r_ready;
    logic                      fi_r_trigger;
    logic [img_pkg::WORD_W-1:0] fi_r_data;

    logic                      fo_flush;
    logic                      fo_w_ready;
    logic                      fo_w_trigger;

    logic                      capture_pulse_clk;
    logic                      readout_pulse;
    logic                      cap_toggle;
    logic                      cap_pulse_dclk;
    logic                      started_toggle;
    logic                      started_pulse;
    logic                      px_done;
    logic                      done_meta;
    logic                      done_sync;
    logic [CNT_W-1:0]          remaining;
    logic                      more_words;

    // ============================================================
    // Command and handshake synchronizers
    // ============================================================
    toggle_sync u_cmd_capture_sync (
        .clk(clk), .arst_n(arst_n), .toggle(cmd_capture), .pulse(capture_pulse_clk)
    );
    toggle_sync u_cmd_readout_sync (
        .clk(clk), .arst_n(arst_n), .toggle(cmd_readout), .pulse(readout_pulse)
    );
    toggle_sync u_capture_sync (
        .clk(img_dclk), .arst_n(arst_n), .toggle(cap_toggle), .pulse(cap_pulse_dclk)
    );
    toggle_sync u_started_sync (
        .clk(clk), .arst_n(arst_n), .toggle(started_toggle), .pulse(started_pulse)
    );

    // ============================================================
    // Pixel side, input FIFO, frame store, output FIFO
    // ============================================================
    pixel_capture #(
        .HEADER_WORDS(HEADER_WORDS),
        .IMAGE_WORDS_MAX(IMAGE_WORDS_MAX)
    ) u_pixel_capture (
        .img_dclk(img_dclk), .arst_n(arst_n), .capture_pulse(cap_pulse_dclk),
        .header(cmd_header), .img_d(img_d), .img_fv(img_fv), .img_lv(img_lv),
        .fifo_flush(fi_flush), .fifo_write(fi_write), .fifo_data(fi_data),
        .started_toggle(started_toggle), .done(px_done),
        .word_count(capture_word_count),
        .highlight_count(highlight_count), .shadow_count(shadow_count)
    );

    async_fifo #(.DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo_in (
        .arst_n(arst_n), .flush(fi_flush),
        .w_clk(img_dclk), .w_ready(fi_w_ready), .w_trigger(fi_write), .w_data(fi_data),
        .r_clk(clk), .r_ready(fi_r_ready), .r_trigger(fi_r_trigger), .r_data(fi_r_data)
    );

    frame_store #(.IMAGE_WORDS_MAX(IMAGE_WORDS_MAX)) u_frame_store (
        .clk(clk), .arst_n(arst_n), .cmd(fs_cmd), .block(fs_block),
        .write_ready(fs_write_ready), .write_trigger(wr_valid), .write_data(wr_data),
        .read_ready(fs_read_ready), .read_trigger(fs_read_trigger), .read_data(fs_read_data)
    );

    async_fifo #(.DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo_out (
        .arst_n(arst_n), .flush(fo_flush),
        .w_clk(clk), .w_ready(fo_w_ready), .w_trigger(fo_w_trigger), .w_data(fs_read_data),
        .r_clk(readout_clk), .r_ready(readout_ready), .r_trigger(readout_trigger),
        .r_data(readout_data)
    );

    // Pop whenever the write register is free or being accepted
    assign fi_r_trigger = state == ST_CAP_COPY && (!wr_valid || fs_write_ready);

    // Readout stops moving words once the remaining count is spent
    assign more_words = state == ST_RD_DRAIN && remaining != '0;
    assign fo_w_trigger = fs_read_ready && more_words;
    assign fs_read_trigger = fo_w_ready && more_words;

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            fs_cmd <= img_pkg::CMD_NONE;
            fs_block <= 1'b0;
            wr_valid <= 1'b0;
            fo_flush <= 1'b0;
            cap_toggle <= 1'b0;
            capture_done <= 1'b0;
            remaining <= '0;
            done_meta <= 1'b0;
            done_sync <= 1'b0;
        end else begin
            fs_cmd <= img_pkg::CMD_NONE;
            fo_flush <= 1'b0;
            done_meta <= px_done;
            done_sync <= done_meta;
            if (wr_valid && fs_write_ready) begin
                wr_valid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (capture_pulse_clk) begin
                        state <= ST_CAP_ISSUE;
                    end else if (readout_pulse) begin
                        state <= ST_RD_ISSUE;
                    end
                end
                ST_CAP_ISSUE: begin
                    fs_cmd <= img_pkg::CMD_WRITE;
                    fs_block <= cmd_block;
                    state <= ST_CAP_WAIT_READY;
                end
                ST_CAP_WAIT_READY: begin
                    if (fs_cmd == img_pkg::CMD_NONE && fs_write_ready) begin
                        cap_toggle <= ~cap_toggle;
                        state <= ST_CAP_WAIT_STARTED;
                    end
                end
                ST_CAP_WAIT_STARTED: if (started_pulse) state <= ST_CAP_COPY;
                ST_CAP_COPY: begin
                    if (fi_r_ready && fi_r_trigger) begin
                        wr_valid <= 1'b1;
                    end
                    // Done once the pixel side has finished and everything is flushed
                    if (done_sync && !fi_r_ready && (!wr_valid || fs_write_ready)) begin
                        capture_done <= ~capture_done;
                        state <= ST_IDLE;
                    end
                end
                ST_RD_ISSUE: begin
                    fs_cmd <= img_pkg::CMD_READ;
                    fs_block <= cmd_block;
                    fo_flush <= 1'b1;
                    remaining <= capture_word_count;
                    state <= ST_RD_WAIT;
                end
                ST_RD_WAIT: begin
                    if (fs_cmd == img_pkg::CMD_NONE && !fo_flush) begin
                        state <= ST_RD_DRAIN;
                    end
                end
                ST_RD_DRAIN: begin
                    if (fo_w_trigger && fo_w_ready) begin
                        remaining <= remaining - 1'b1;
                    end
                    if (remaining == '0) begin
                        fs_cmd <= img_pkg::CMD_STOP;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fi_r_ready && fi_r_trigger) begin
            wr_data <= fi_r_data;
        end
    end

endmodule

`default_nettype wire

// ==== img_controller_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module img_controller_chk (
    input  logic              clk,
    input  logic              img_dclk,
    input  logic              arst_n,
    input  logic [2:0]        state,
    input  img_pkg::ram_cmd_e fs_cmd,
    input  logic              capture_done,
    input  logic              readout_ready,
    input  logic              fi_write,
    input  logic              fi_w_ready
);

    // Encoding of the capture copy state in the control FSM
    localparam logic [2:0] ST_CAP_COPY = 3'd4;

    int fail_count = 0;

    // ============================================================
    // Protocol properties
    // ============================================================
    a_ready_in_reset: assert property (@(posedge clk) !arst_n |-> !readout_ready)
    else begin
        fail_count++;
        $error("readout_ready is high while arst_n is low");
    end

    a_done_in_copy: assert property (@(posedge clk) disable iff (!arst_n)
        capture_done != $past(capture_done) |-> $past(state) == ST_CAP_COPY)
    else begin
        fail_count++;
        $error("capture_done changed outside the capture copy state");
    end

    a_cmd_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        fs_cmd != img_pkg::CMD_NONE |-> $past(fs_cmd) == img_pkg::CMD_NONE)
    else begin
        fail_count++;
        $error("frame store command held for more than one cycle");
    end

    // Input FIFO writes have no back pressure, so a full FIFO would drop pixels
    a_in_fifo_room: assert property (@(posedge img_dclk) disable iff (!arst_n)
        fi_write |-> fi_w_ready)
    else begin
        fail_count++;
        $error("input FIFO written while full");
    end

endmodule

`default_nettype wire

// ==== img_pkg.sv ====
`default_nettype none

package img_pkg;

    // ============================================================
    // Word and pixel widths
    // ============================================================
    localparam int WORD_W = 16;
    localparam int PIXEL_W = 12;

    // ============================================================
    // Highlight and shadow statistics
    // ============================================================
    localparam int STAT_W = 18;
    // Top pixel bits that classify a sampled pixel
    localparam int STAT_BITS = 7;

    // Frame store command
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2,
        CMD_STOP  = 2'd3
    } ram_cmd_e;

endpackage

`default_nettype wire

// ==== pixel_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_capture #(
    parameter int HEADER_WORDS = 4,
    parameter int IMAGE_WORDS_MAX = 256,
    localparam int CNT_W = $clog2(IMAGE_WORDS_MAX + 1),
    localparam int HDR_W = HEADER_WORDS * img_pkg::WORD_W
) (
    input  logic                       img_dclk,
    input  logic                       arst_n,
    input  logic                       capture_pulse,
    input  logic [HDR_W-1:0]           header,
    input  logic [img_pkg::PIXEL_W-1:0] img_d,
    input  logic                       img_fv,
    input  logic                       img_lv,
    output logic                       fifo_flush,
    output logic                       fifo_write,
    output logic [img_pkg::WORD_W-1:0]  fifo_data,
    output logic                       started_toggle,
    output logic                       done,
    output logic [CNT_W-1:0]           word_count,
    output logic [img_pkg::STAT_W-1:0]  highlight_count,
    output logic [img_pkg::STAT_W-1:0]  shadow_count
);

    localparam int HCNT_W = $clog2(HEADER_WORDS + 1);
    localparam int PAD_W = img_pkg::WORD_W - img_pkg::PIXEL_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FLUSH,
        ST_SETTLE,
        ST_LOAD_HDR,
        ST_HEADER,
        ST_WAIT_FV_LOW,
        ST_WAIT_FV_HIGH,
        ST_FRAME
    } state_e;

    state_e                     state;
    logic [img_pkg::PIXEL_W-1:0] img_d_q;
    logic                       fv_q;
    logic                       lv_q;
    logic                       lv_prev;
    logic [1:0]                 col;
    logic [1:0]                 row;
    logic                       stat_en;
    logic [img_pkg::PIXEL_W-1:0] stat_px;
    logic [HDR_W-1:0]           hdr_shift;
    logic [HCNT_W-1:0]          hdr_cnt;

    // ============================================================
    // Control and counters
    // ============================================================
    always_ff @(posedge img_dclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            fv_q <= 1'b0;
            lv_q <= 1'b0;
            lv_prev <= 1'b0;
            col <= '0;
            row <= '0;
            stat_en <= 1'b0;
            hdr_cnt <= '0;
            fifo_flush <= 1'b0;
            fifo_write <= 1'b0;
            started_toggle <= 1'b0;
            done <= 1'b0;
            word_count <= '0;
            highlight_count <= '0;
            shadow_count <= '0;
        end else begin
            fv_q <= img_fv;
            lv_q <= img_lv;
            lv_prev <= lv_q;
            fifo_flush <= 1'b0;
            fifo_write <= 1'b0;
            stat_en <= 1'b0;

            // Tile position, modulo 4 from line start and frame start
            col <= lv_q ? col + 2'd1 : 2'd0;
            if (!fv_q) begin
                row <= '0;
            end else if (lv_prev && !lv_q) begin
                row <= row + 2'd1;
            end

            if (fifo_write) begin
                word_count <= word_count + 1'b1;
            end

            if (stat_en) begin
                if (&stat_px[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS]) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (~|stat_px[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS]) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                ST_FLUSH: begin
                    fifo_flush <= 1'b1;
                    done <= 1'b0;
                    word_count <= '0;
                    highlight_count <= '0;
                    shadow_count <= '0;
                    state <= ST_SETTLE;
                end
                // FIFO comes out of reset here
                ST_SETTLE: state <= ST_LOAD_HDR;
                ST_LOAD_HDR: begin
                    started_toggle <= ~started_toggle;
                    hdr_cnt <= HCNT_W'(HEADER_WORDS - 1);
                    state <= ST_HEADER;
                end
                ST_HEADER: begin
                    fifo_write <= 1'b1;
                    hdr_cnt <= hdr_cnt - 1'b1;
                    if (hdr_cnt == '0) begin
                        state <= ST_WAIT_FV_LOW;
                    end
                end
                // Skip any frame already in progress
                ST_WAIT_FV_LOW: if (!fv_q) state <= ST_WAIT_FV_HIGH;
                ST_WAIT_FV_HIGH: if (fv_q) state <= ST_FRAME;
                ST_FRAME: begin
                    fifo_write <= lv_q;
                    stat_en <= lv_q && col == 2'd0 && row == 2'd0;
                    if (!fv_q) begin
                        done <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: ;
            endcase

            if (capture_pulse) begin
                state <= ST_FLUSH;
            end
        end
    end

    // ============================================================
    // Pixel, header and FIFO data path
    // ============================================================
    always_ff @(posedge img_dclk) begin
        img_d_q <= img_d;
        stat_px <= img_d_q;
        if (state == ST_LOAD_HDR) begin
            hdr_shift <= header;
        end else begin
            hdr_shift <= hdr_shift << img_pkg::WORD_W;
        end
        if (state == ST_HEADER) begin
            fifo_data <= hdr_shift[HDR_W-1 -: img_pkg::WORD_W];
        end else begin
            fifo_data <= {{PAD_W{1'b0}}, img_d_q};
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the image controller testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_img_controller -f compile.f \
    --Mdir obj_dir -o tb_img_controller_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_img_controller_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// ==== tb_img_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_img_controller;

    localparam int IMAGE_WORDS_MAX = 256;
    localparam int HEADER_WORDS = 4;
    localparam int FIFO_DEPTH_LOG2 = 4;
    localparam int CNT_W = $clog2(IMAGE_WORDS_MAX + 1);
    localparam int WORD_W = img_pkg::WORD_W;
    localparam int LINES = 8;
    localparam int PIXELS = 12;
    localparam int LINE_GAP = 6;
    // Two captures of two frames each plus three readouts, one with long stalls
    localparam int CYCLE_LIMIT = 20000;

    logic                           clk;
    logic                           readout_clk;
    logic                           img_dclk;
    logic                           arst_n;
    logic                           cmd_capture;
    logic                           cmd_readout;
    logic                           cmd_block;
    logic [HEADER_WORDS*WORD_W-1:0] cmd_header;
    logic                           readout_ready;
    logic                           readout_trigger;
    logic [WORD_W-1:0]              readout_data;
    logic                           capture_done;
    logic [CNT_W-1:0]               capture_word_count;
    logic [img_pkg::STAT_W-1:0]     highlight_count;
    logic [img_pkg::STAT_W-1:0]     shadow_count;
    logic [img_pkg::PIXEL_W-1:0]    img_d;
    logic                           img_fv;
    logic                           img_lv;

    int                             seed;
    int                             cycles;
    int                             exp_highlight;
    int                             exp_shadow;
    logic [WORD_W-1:0]              exp_words[$];
    logic [WORD_W-1:0]              block0_words[$];

    img_controller #(
        .IMAGE_WORDS_MAX(IMAGE_WORDS_MAX),
        .HEADER_WORDS(HEADER_WORDS),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) dut (
        .clk(clk), .readout_clk(readout_clk), .img_dclk(img_dclk), .arst_n(arst_n),
        .cmd_capture(cmd_capture), .cmd_readout(cmd_readout), .cmd_block(cmd_block),
        .cmd_header(cmd_header), .readout_ready(readout_ready),
        .readout_trigger(readout_trigger), .readout_data(readout_data),
        .capture_done(capture_done), .capture_word_count(capture_word_count),
        .highlight_count(highlight_count), .shadow_count(shadow_count),
        .img_d(img_d), .img_fv(img_fv), .img_lv(img_lv)
    );

    bind img_controller img_controller_chk u_chk (
        .clk(clk), .img_dclk(img_dclk), .arst_n(arst_n), .state(state), .fs_cmd(fs_cmd),
        .capture_done(capture_done), .readout_ready(readout_ready),
        .fi_write(fi_write), .fi_w_ready(fi_w_ready)
    );

    // ============================================================
    // Clocks and timeout
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        img_dclk = 1'b0;
        forever #4 img_dclk = ~img_dclk;
    end

    initial begin
        readout_clk = 1'b0;
        forever #3 readout_clk = ~readout_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the test did not finish within %0d clk cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $fatal(1);
    end

    // Stop at the first failure of a bound protocol property
    always @(posedge clk) begin
        if (dut.u_chk.fail_count != 0) begin
            $display("A protocol property of the controller failed");
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // ============================================================
    // Frame generator and reference model
    // ============================================================
    task automatic drive_frame(input bit record);
        int r;
        int c;
        logic [img_pkg::PIXEL_W-1:0] px;
        @(posedge img_dclk);
        #1 img_fv = 1'b1;
        repeat (2) @(posedge img_dclk);
        for (r = 0; r < LINES; r++) begin
            for (c = 0; c < PIXELS; c++) begin
                px = 12'($random(seed));
                // Full scale and zero tiles, plus bright pixels off the sample grid
                if (r % 4 == 0 && c == 0) begin
                    px = px | 12'hfe0;
                end else if (r % 4 == 0 && c == 4) begin
                    px = px & 12'h01f;
                end else if (c == 1) begin
                    px = px | 12'hfe0;
                end
                @(posedge img_dclk);
                #1;
                img_lv = 1'b1;
                img_d = px;
                if (record) begin
                    exp_words.push_back({4'h0, px});
                    // Tile sample where row and column are both zero modulo 4
                    if (r % 4 == 0 && c % 4 == 0) begin
                        if (px[11:5] == 7'h7f) begin
                            exp_highlight++;
                        end else if (px[11:5] == 7'h00) begin
                            exp_shadow++;
                        end
                    end
                end
            end
            repeat (LINE_GAP) begin
                @(posedge img_dclk);
                #1 img_lv = 1'b0;
            end
        end
        @(posedge img_dclk);
        #1 img_fv = 1'b0;
        repeat (4) @(posedge img_dclk);
    endtask

    // Command lands in the middle of a frame that must be skipped
    task automatic capture(input logic blk);
        int h;
        logic done_before;
        logic [WORD_W-1:0] word;
        exp_words.delete();
        exp_highlight = 0;
        exp_shadow = 0;
        done_before = capture_done;
        @(posedge clk);
        #1;
        cmd_block = blk;
        for (h = 0; h < HEADER_WORDS; h++) begin
            word = 16'($random(seed));
            cmd_header[(HEADER_WORDS-1-h)*WORD_W +: WORD_W] = word;
            exp_words.push_back(word);
        end
        fork
            drive_frame(1'b0);
            begin
                repeat (40) @(posedge img_dclk);
                @(posedge clk);
                #1 cmd_capture = ~cmd_capture;
            end
        join
        drive_frame(1'b1);
        wait (capture_done != done_before);
        @(posedge clk);
        #1;
        check_value("capture_word_count", exp_words.size(), int'(capture_word_count));
        check_value("highlight_count", exp_highlight, int'(highlight_count));
        check_value("shadow_count", exp_shadow, int'(shadow_count));
    endtask

    task automatic read_block(input logic blk, input bit pause);
        int idx;
        int stall;
        idx = 0;
        stall = 0;
        @(posedge clk);
        #1;
        cmd_block = blk;
        cmd_readout = ~cmd_readout;
        while (idx < exp_words.size()) begin
            @(posedge readout_clk);
            #1;
            if (stall > 0) begin
                stall--;
                readout_trigger = 1'b0;
            end else if (readout_ready) begin
                check_value("readout_data", int'(exp_words[idx]), int'(readout_data));
                idx++;
                readout_trigger = 1'b1;
                // Long enough for the output FIFO to fill and stall the frame store
                if (pause && idx % 32 == 8) begin
                    stall = 60;
                end
            end else begin
                readout_trigger = 1'b0;
            end
        end
        @(posedge readout_clk);
        #1 readout_trigger = 1'b0;
        // No word may follow the last stored one
        repeat (30) @(posedge readout_clk);
        #1;
        check_value("readout_ready", 0, int'(readout_ready));
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        seed = 11;
        arst_n = 1'b1;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_block = 1'b0;
        cmd_header = '0;
        readout_trigger = 1'b0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        #1 arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        check_value("readout_ready", 0, int'(readout_ready));
        check_value("capture_word_count", 0, int'(capture_word_count));
        check_value("highlight_count", 0, int'(highlight_count));
        check_value("shadow_count", 0, int'(shadow_count));

        capture(1'b0);
        block0_words = exp_words;
        read_block(1'b0, 1'b0);
        read_block(1'b0, 1'b1);

        // A second frame into block 1 must leave block 0 intact
        capture(1'b1);
        exp_words = block0_words;
        read_block(1'b0, 1'b0);

        if (dut.u_chk.fail_count != 0) begin
            $display("Protocol checks failed %0d times", dut.u_chk.fail_count);
            $display("Result: FAILED");
            $fatal(1);
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== toggle_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module toggle_sync (
    input  logic clk,
    input  logic arst_n,
    input  logic toggle,
    output logic pulse
);

    logic sync_meta;
    logic sync_q;
    logic sync_prev;

    // Two synchronizer flops plus one flop for the edge compare
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_meta <= 1'b0;
            sync_q <= 1'b0;
            sync_prev <= 1'b0;
        end else begin
            sync_meta <= toggle;
            sync_q <= sync_meta;
            sync_prev <= sync_q;
        end
    end

    assign pulse = sync_q ^ sync_prev;

endmodule

`default_nettype wire
